// File: compy_video_bus.f
+incdir+rtl
rtl/compy_pkg.sv
rtl/vram_fetch_if.sv
rtl/mode_selector.sv
rtl/video_ram.sv
rtl/vram_arbiter.sv
rtl/compy_video_bus.sv
verif/vram_arbiter_checker.sv
verif/compy_video_bus_tb.sv

// File: rtl/compy_defines.svh
`ifndef COMPY_DEFINES_SVH
`define COMPY_DEFINES_SVH

// bus and datapath widths
`define ADDR_W        16
`define DATA_W        8
`define VRAM_AW       11

// video fetch port
`define PAGE_W        8
`define OFS_W         14
`define PAGE_SHIFT    9

// host memory map
`define VRAM_LO       16'hA000
`define VRAM_HI       16'hDFFF
`define MODE_REG_ADDR 16'h9000
`define UNMAPPED_DATA 8'hFF

`endif

// File: rtl/compy_pkg.sv
`default_nettype none

package compy_pkg;

   // display modes, encoding shared with the video clocking logic
   typedef enum logic [1:0] {
      MODE_640X480   = 2'd0,
      MODE_800X600   = 2'd1,
      MODE_1920X1080 = 2'd2
   } vga_mode_t;

   // what a host address lands on
   typedef enum logic [1:0] {
      REGION_VRAM     = 2'd0,
      REGION_MODE_REG = 2'd1,
      REGION_NONE     = 2'd2
   } bus_region_t;

endpackage

`default_nettype wire

// File: rtl/compy_video_bus.sv
`timescale 1ns/1ps
`default_nettype none
`include "compy_defines.svh"

module compy_video_bus (
   input  logic                 sys_clk,
   input  logic                 reset_n,
   input  logic                 key_mode,
   input  logic [`PAGE_W-1:0]   fetch_page,
   input  logic [`OFS_W-1:0]    fetch_offset,
   input  logic                 fetch_req,
   output logic                 fetch_ack,
   output logic [`DATA_W-1:0]   fetch_data,
   input  logic                 wb_cyc,
   input  logic                 wb_stb,
   input  logic                 wb_we,
   input  logic [`ADDR_W-1:0]   wb_adr,
   input  logic [`DATA_W-1:0]   wb_dat_w,
   output logic [`DATA_W-1:0]   wb_dat_r,
   output logic                 wb_ack,
   output compy_pkg::vga_mode_t vga_mode
);

   import compy_pkg::*;

   logic                mode_wr;
   vga_mode_t           mode_wdata;
   logic                ram_we;
   logic [`VRAM_AW-1:0] ram_addr;
   logic [`DATA_W-1:0]  ram_wdata;
   logic [`DATA_W-1:0]  ram_rdata;

   vram_fetch_if fetch_bus ();

   // video controller side of the fetch port
   assign fetch_bus.page   = fetch_page;
   assign fetch_bus.offset = fetch_offset;
   assign fetch_bus.req    = fetch_req;
   assign fetch_ack        = fetch_bus.ack;
   assign fetch_data       = fetch_bus.data;

   mode_selector u_mode_selector (
      .sys_clk    (sys_clk),
      .reset_n    (reset_n),
      .key_mode   (key_mode),
      .mode_wr    (mode_wr),
      .mode_wdata (mode_wdata),
      .vga_mode   (vga_mode)
   );

   video_ram u_video_ram (
      .sys_clk (sys_clk),
      .we      (ram_we),
      .addr    (ram_addr),
      .wdata   (ram_wdata),
      .rdata   (ram_rdata)
   );

   vram_arbiter u_vram_arbiter (
      .sys_clk    (sys_clk),
      .reset_n    (reset_n),
      .fetch      (fetch_bus),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .vga_mode   (vga_mode),
      .mode_wr    (mode_wr),
      .mode_wdata (mode_wdata),
      .ram_we     (ram_we),
      .ram_addr   (ram_addr),
      .ram_wdata  (ram_wdata),
      .ram_rdata  (ram_rdata)
   );

endmodule

`default_nettype wire

// File: rtl/mode_selector.sv
`timescale 1ns/1ps
`default_nettype none

module mode_selector (
   input  logic                sys_clk,
   input  logic                reset_n,
   input  logic                key_mode,
   input  logic                mode_wr,
   input  compy_pkg::vga_mode_t mode_wdata,
   output compy_pkg::vga_mode_t vga_mode
);

   import compy_pkg::*;

   logic [1:0] key_sync; // two flop synchronizer
   logic       key_prev;
   logic       key_fall;
   vga_mode_t  next_mode;
   vga_mode_t  wr_mode;

   // key is idle high, so reset the chain high to avoid a false edge
   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         key_sync <= 2'b11;
         key_prev <= 1'b1;
      end else begin
         key_sync <= {key_sync[0], key_mode};
         key_prev <= key_sync[1];
      end
   end

   assign key_fall = key_prev & ~key_sync[1]; // press detected

   always_comb begin
      case (vga_mode)
         MODE_640X480: next_mode = MODE_800X600;
         MODE_800X600: next_mode = MODE_1920X1080;
         default:      next_mode = MODE_640X480; // 1080 wraps around
      endcase
   end

   always_comb begin
      case (mode_wdata)
         MODE_640X480, MODE_800X600, MODE_1920X1080: wr_mode = mode_wdata;
         default: wr_mode = MODE_640X480; // encoding 3 is unused
      endcase
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         vga_mode <= MODE_1920X1080;
      end else if (key_fall) begin
         vga_mode <= next_mode; // key wins over a host write
      end else if (mode_wr) begin
         vga_mode <= wr_mode;
      end
   end

endmodule

`default_nettype wire

// File: rtl/video_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "compy_defines.svh"

module video_ram (
   input  logic                sys_clk,
   input  logic                we,
   input  logic [`VRAM_AW-1:0] addr,
   input  logic [`DATA_W-1:0]  wdata,
   output logic [`DATA_W-1:0]  rdata
);

   localparam int DEPTH = 1 << `VRAM_AW;

   logic [`DATA_W-1:0] mem [DEPTH];

   // registered read, a write shows its own data on the port
   always_ff @(posedge sys_clk) begin
      if (we) begin
         mem[addr] <= wdata;
         rdata     <= wdata;
      end else begin
         rdata <= mem[addr];
      end
   end

endmodule

`default_nettype wire

// File: rtl/vram_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "compy_defines.svh"

module vram_arbiter (
   input  logic                 sys_clk,
   input  logic                 reset_n,
   vram_fetch_if.server         fetch,
   input  logic                 wb_cyc,
   input  logic                 wb_stb,
   input  logic                 wb_we,
   input  logic [`ADDR_W-1:0]   wb_adr,
   input  logic [`DATA_W-1:0]   wb_dat_w,
   output logic [`DATA_W-1:0]   wb_dat_r,
   output logic                 wb_ack,
   input  compy_pkg::vga_mode_t vga_mode,
   output logic                 mode_wr,
   output compy_pkg::vga_mode_t mode_wdata,
   output logic                 ram_we,
   output logic [`VRAM_AW-1:0]  ram_addr,
   output logic [`DATA_W-1:0]   ram_wdata,
   input  logic [`DATA_W-1:0]   ram_rdata
);

   import compy_pkg::*;

   localparam int LIN_W = `PAGE_W + `PAGE_SHIFT;

   typedef enum logic [1:0] {
      READY   = 2'd0,
      ADDR    = 2'd1,
      CAPTURE = 2'd2,
      ACK     = 2'd3
   } arb_state_t;

   arb_state_t         state;
   logic               serving_host; // current cycle belongs to the host
   logic               host_turn;    // host goes first at the next READY
   logic               host_req;
   logic               fetch_go;
   logic [LIN_W-1:0]   fetch_lin;
   bus_region_t        host_region_d;
   bus_region_t        host_region;
   logic               host_we;
   logic [`VRAM_AW-1:0] addr_q;
   logic [`DATA_W-1:0] wdata_q;
   logic [`DATA_W-1:0] rdata_q;
   logic               fetch_ack_q;
   logic               wb_ack_q;

   assign host_req = wb_cyc & wb_stb;

   // a fetch loses only when the host already waited through one
   assign fetch_go = fetch.req & ~(host_turn & host_req);

   // page * 512 + offset
   assign fetch_lin = {fetch.page, {`PAGE_SHIFT{1'b0}}} + LIN_W'(fetch.offset);

   always_comb begin
      if (wb_adr >= `VRAM_LO && wb_adr <= `VRAM_HI) begin
         host_region_d = REGION_VRAM;
      end else if (wb_adr == `MODE_REG_ADDR) begin
         host_region_d = REGION_MODE_REG;
      end else begin
         host_region_d = REGION_NONE; // storage, keyboard, sound etc
      end
   end

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         state        <= READY;
         serving_host <= 1'b0;
         host_turn    <= 1'b0;
         fetch_ack_q  <= 1'b0;
         wb_ack_q     <= 1'b0;
      end else begin
         case (state)
            READY: begin
               if (fetch_go) begin
                  state        <= ADDR;
                  serving_host <= 1'b0;
                  host_turn    <= host_req; // host is next if it is waiting
               end else if (host_req) begin
                  state        <= ADDR;
                  serving_host <= 1'b1;
                  host_turn    <= 1'b0;
               end
            end
            ADDR: begin
               state <= CAPTURE; // RAM samples address on this edge
            end
            CAPTURE: begin
               state       <= ACK;
               fetch_ack_q <= ~serving_host;
               wb_ack_q    <= serving_host;
            end
            ACK: begin
               state       <= READY;
               fetch_ack_q <= 1'b0;
               wb_ack_q    <= 1'b0;
            end
            default: state <= READY;
         endcase
      end
   end

   // request payload, latched when READY accepts
   always_ff @(posedge sys_clk) begin
      if (state == READY) begin
         if (fetch_go) begin
            addr_q <= fetch_lin[`VRAM_AW-1:0]; // wraps inside 2 KiB
         end else begin
            addr_q      <= wb_adr[`VRAM_AW-1:0];
            wdata_q     <= wb_dat_w;
            host_we     <= wb_we;
            host_region <= host_region_d;
         end
      end
   end

   // read data for either side, captured the cycle before ack
   always_ff @(posedge sys_clk) begin
      if (state == CAPTURE) begin
         if (!serving_host) begin
            rdata_q <= ram_rdata;
         end else begin
            case (host_region)
               REGION_VRAM:     rdata_q <= ram_rdata;
               REGION_MODE_REG: rdata_q <= (`DATA_W)'(vga_mode); // zero-extended
               default:         rdata_q <= `UNMAPPED_DATA;
            endcase
         end
      end
   end

   assign ram_addr  = addr_q;
   assign ram_wdata = wdata_q;
   assign ram_we    = (state == ADDR) && serving_host && host_we &&
                      (host_region == REGION_VRAM);

   // mode register loads on the ack edge
   assign mode_wr    = (state == ACK) && serving_host && host_we &&
                       (host_region == REGION_MODE_REG);
   assign mode_wdata = vga_mode_t'(wdata_q[1:0]);

   assign fetch.ack  = fetch_ack_q;
   assign fetch.data = rdata_q;
   assign wb_ack     = wb_ack_q;
   assign wb_dat_r   = rdata_q;

endmodule

`default_nettype wire

// File: rtl/vram_fetch_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "compy_defines.svh"

interface vram_fetch_if;

   logic [`PAGE_W-1:0] page;   // 512 byte page
   logic [`OFS_W-1:0]  offset; // byte offset from page base
   logic               req;    // held until ack
   logic               ack;    // one cycle pulse
   logic [`DATA_W-1:0] data;   // valid with ack

   modport requester (
      output page, offset, req,
      input  ack, data
   );

   modport server (
      input  page, offset, req,
      output ack, data
   );

endinterface

`default_nettype wire

// File: verif/compy_video_bus_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "compy_defines.svh"

module compy_video_bus_tb;

   import compy_pkg::*;

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 16;
   localparam int ACK_TIMEOUT  = 16; // cycles allowed for any ack
   localparam int N_RAND       = 32;
   localparam int N_FETCH      = 32;
   localparam int N_PAR        = 4;
   localparam int OP_CYCLES    = 8;  // bound for one bus operation
   localparam int TEST_CYCLES  = RESET_CYCLES + 4 * 16 +
                                 OP_CYCLES * (2048 + 2 * N_RAND + N_FETCH + 20 + 2 * N_PAR);

   logic               sys_clk;
   logic               reset_n;
   logic               key_mode;
   logic [`PAGE_W-1:0] fetch_page;
   logic [`OFS_W-1:0]  fetch_offset;
   logic               fetch_req;
   logic               fetch_ack;
   logic [`DATA_W-1:0] fetch_data;
   logic               wb_cyc;
   logic               wb_stb;
   logic               wb_we;
   logic [`ADDR_W-1:0] wb_adr;
   logic [`DATA_W-1:0] wb_dat_w;
   logic [`DATA_W-1:0] wb_dat_r;
   logic               wb_ack;
   vga_mode_t          vga_mode;

   logic [`DATA_W-1:0] ref_mem [2048]; // mirror of host writes to VRAM
   int                 error_count;

   compy_video_bus uut (
      .sys_clk      (sys_clk),
      .reset_n      (reset_n),
      .key_mode     (key_mode),
      .fetch_page   (fetch_page),
      .fetch_offset (fetch_offset),
      .fetch_req    (fetch_req),
      .fetch_ack    (fetch_ack),
      .fetch_data   (fetch_data),
      .wb_cyc       (wb_cyc),
      .wb_stb       (wb_stb),
      .wb_we        (wb_we),
      .wb_adr       (wb_adr),
      .wb_dat_w     (wb_dat_w),
      .wb_dat_r     (wb_dat_r),
      .wb_ack       (wb_ack),
      .vga_mode     (vga_mode)
   );

   bind vram_arbiter vram_arbiter_checker u_arb_checker (
      .sys_clk     (sys_clk),
      .reset_n     (reset_n),
      .fetch_req   (fetch.req),
      .fetch_ack   (fetch.ack),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_ack      (wb_ack),
      .wb_dat_r    (wb_dat_r),
      .in_ready    (state == READY),
      .fetch_go    (fetch_go),
      .host_region (host_region)
   );

   initial begin
      sys_clk = 1'b0;
      forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
   end

   initial begin
      #(TEST_CYCLES * 2 * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, a test is stuck", TEST_CYCLES * 2);
      $display("Test failures found");
      $finish;
   end

   task automatic check_byte(input string name, input logic [`DATA_W-1:0] exp,
                             input logic [`DATA_W-1:0] act);
      if (act !== exp) begin
         error_count++;
         $display("FAIL t=%0t %s expected 8'h%02h actual 8'h%02h", $time, name, exp, act);
      end
   endtask

   task automatic check_mode(input string name, input vga_mode_t exp, input vga_mode_t act);
      if (act !== exp) begin
         error_count++;
         $display("FAIL t=%0t %s expected %s actual %s", $time, name, exp.name(), act.name());
      end
   endtask

   task automatic check_latency(input string name, input int exp, input int act);
      if (act != exp) begin
         error_count++;
         $display("FAIL t=%0t %s expected %0d actual %0d cycles", $time, name, exp, act);
      end
   endtask

   // expected mode after one key press
   function automatic vga_mode_t mode_after_press(input vga_mode_t m);
      case (m)
         MODE_640X480: return MODE_800X600;
         MODE_800X600: return MODE_1920X1080;
         default:      return MODE_640X480;
      endcase
   endfunction

   function automatic int fetch_index(input logic [`PAGE_W-1:0] page,
                                      input logic [`OFS_W-1:0] ofs);
      return ((int'(page) << `PAGE_SHIFT) + int'(ofs)) % 2048; // 2 KiB wrap
   endfunction

   task automatic wb_cycle(input logic we, input logic [`ADDR_W-1:0] adr,
                           input logic [`DATA_W-1:0] dat_w, output logic [`DATA_W-1:0] dat_r,
                           output int latency, output time ack_at);
      int waited;
      @(posedge sys_clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= dat_w;
      waited = 0;
      @(negedge sys_clk);
      while (!wb_ack && waited < ACK_TIMEOUT) begin
         waited++;
         @(negedge sys_clk);
      end
      if (!wb_ack) begin
         error_count++;
         $display("ERROR t=%0t no wb_ack for address %h within %0d cycles", $time, adr, waited);
      end
      dat_r   = wb_dat_r;
      latency = waited;
      ack_at  = $time;
      @(posedge sys_clk);
      wb_cyc <= 1'b0; // end the cycle after the one-cycle ack
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic wb_write(input logic [`ADDR_W-1:0] adr, input logic [`DATA_W-1:0] data);
      logic [`DATA_W-1:0] unused;
      int                 lat;
      time                ack_at;
      wb_cycle(1'b1, adr, data, unused, lat, ack_at);
      check_latency("wb_ack latency", 3, lat);
      if (adr >= `VRAM_LO && adr <= `VRAM_HI) begin
         ref_mem[adr[`VRAM_AW-1:0]] = data; // aliases share the low 11 bits
      end
   endtask

   task automatic wb_read(input logic [`ADDR_W-1:0] adr, output logic [`DATA_W-1:0] data,
                          output int lat, output time ack_at);
      wb_cycle(1'b0, adr, 8'h00, data, lat, ack_at);
   endtask

   task automatic fetch_read(input logic [`PAGE_W-1:0] page, input logic [`OFS_W-1:0] ofs,
                             output logic [`DATA_W-1:0] data, output int lat,
                             output time ack_at);
      int waited;
      @(posedge sys_clk);
      fetch_page   <= page;
      fetch_offset <= ofs;
      fetch_req    <= 1'b1;
      waited = 0;
      @(negedge sys_clk);
      while (!fetch_ack && waited < ACK_TIMEOUT) begin
         waited++;
         @(negedge sys_clk);
      end
      if (!fetch_ack) begin
         error_count++;
         $display("ERROR t=%0t no fetch_ack for page %h within %0d cycles", $time, page, waited);
      end
      data   = fetch_data;
      lat    = waited;
      ack_at = $time;
      @(posedge sys_clk);
      fetch_req <= 1'b0;
   endtask

   task automatic press_key(input vga_mode_t expected);
      int waited;
      @(posedge sys_clk);
      key_mode <= 1'b0;
      waited = 0;
      @(negedge sys_clk);
      while (vga_mode !== expected && waited < 5) begin
         waited++;
         @(negedge sys_clk);
      end
      check_mode("vga_mode", expected, vga_mode);
      repeat (4) @(posedge sys_clk);
      key_mode <= 1'b1;
      repeat (4) @(posedge sys_clk); // let the synchronizer settle
   endtask

   task automatic fill_vram();
      for (int i = 0; i < 2048; i++) begin
         wb_write(16'(`VRAM_LO + i), 8'($urandom));
      end
   endtask

   task automatic random_host_rw();
      logic [`ADDR_W-1:0] addrs[$];
      logic [`ADDR_W-1:0] adr;
      logic [`DATA_W-1:0] rd;
      int                 lat;
      time                ack_at;
      for (int i = 0; i < N_RAND; i++) begin
         adr = 16'(`VRAM_LO + ($urandom % 32'h4000));
         addrs.push_back(adr);
         wb_write(adr, 8'($urandom));
      end
      foreach (addrs[i]) begin
         adr = addrs[i];
         wb_read(adr, rd, lat, ack_at);
         check_byte("wb_dat_r", ref_mem[adr[`VRAM_AW-1:0]], rd);
         check_latency("wb_ack latency", 3, lat);
      end
   endtask

   task automatic random_fetches();
      logic [`PAGE_W-1:0] page;
      logic [`OFS_W-1:0]  ofs;
      logic [`DATA_W-1:0] rd;
      int                 lat;
      time                ack_at;
      for (int i = 0; i < N_FETCH; i++) begin
         page = 8'($urandom);
         ofs  = 14'($urandom);
         fetch_read(page, ofs, rd, lat, ack_at);
         check_byte("fetch_data", ref_mem[fetch_index(page, ofs)], rd);
         check_latency("fetch_ack latency", 3, lat);
      end
   endtask

   task automatic mode_register_rw();
      logic [`DATA_W-1:0] rd;
      int                 lat;
      time                ack_at;
      vga_mode_t          expected;
      @(negedge sys_clk);
      check_mode("vga_mode", MODE_1920X1080, vga_mode);
      wb_read(`MODE_REG_ADDR, rd, lat, ack_at);
      check_byte("wb_dat_r", 8'(MODE_1920X1080), rd);
      check_latency("wb_ack latency", 3, lat);
      for (int i = 0; i < 4; i++) begin
         expected = (i == 3) ? MODE_640X480 : vga_mode_t'(i); // encoding 3 stores 640x480
         wb_write(`MODE_REG_ADDR, 8'(i));
         @(negedge sys_clk);
         check_mode("vga_mode", expected, vga_mode);
         wb_read(`MODE_REG_ADDR, rd, lat, ack_at);
         check_byte("wb_dat_r", 8'(expected), rd);
      end
   endtask

   task automatic key_press_sequence();
      vga_mode_t expected;
      wb_write(`MODE_REG_ADDR, 8'(MODE_640X480)); // known starting mode
      expected = MODE_640X480;
      for (int i = 0; i < 4; i++) begin
         expected = mode_after_press(expected); // four presses cover the wrap
         press_key(expected);
      end
   endtask

   task automatic unmapped_access();
      logic [`DATA_W-1:0] rd;
      int                 lat;
      time                ack_at;
      vga_mode_t          mode_before;
      mode_before = MODE_800X600;
      wb_write(`MODE_REG_ADDR, 8'(mode_before));
      wb_read(16'h9090, rd, lat, ack_at);
      check_byte("wb_dat_r", `UNMAPPED_DATA, rd);
      check_latency("wb_ack latency", 3, lat);
      wb_read(16'h0100, rd, lat, ack_at);
      check_byte("wb_dat_r", `UNMAPPED_DATA, rd);
      check_latency("wb_ack latency", 3, lat);
      wb_write(16'h0100, ~ref_mem[11'h100]);
      wb_write(16'h9090, 8'(MODE_1920X1080)); // differs from the stored mode
      wb_read(16'hA100, rd, lat, ack_at); // same low bits as 0x0100
      check_byte("wb_dat_r", ref_mem[11'h100], rd);
      wb_read(16'hA090, rd, lat, ack_at);
      check_byte("wb_dat_r", ref_mem[11'h090], rd);
      wb_read(`MODE_REG_ADDR, rd, lat, ack_at);
      check_byte("wb_dat_r", 8'(mode_before), rd);
      @(negedge sys_clk);
      check_mode("vga_mode", mode_before, vga_mode);
   endtask

   task automatic concurrent_fetch_host();
      logic [`PAGE_W-1:0] page;
      logic [`OFS_W-1:0]  ofs;
      logic [`ADDR_W-1:0] adr;
      logic [`DATA_W-1:0] f_data;
      logic [`DATA_W-1:0] h_data;
      int                 f_lat;
      int                 h_lat;
      time                f_at;
      time                h_at;
      for (int i = 0; i < N_PAR; i++) begin
         page = 8'($urandom);
         ofs  = 14'($urandom);
         adr  = 16'(`VRAM_LO + ($urandom % 32'h4000));
         fork
            fetch_read(page, ofs, f_data, f_lat, f_at);
            wb_read(adr, h_data, h_lat, h_at);
         join
         check_byte("fetch_data", ref_mem[fetch_index(page, ofs)], f_data);
         check_byte("wb_dat_r", ref_mem[adr[`VRAM_AW-1:0]], h_data);
         if (f_at >= h_at) begin
            error_count++;
            $display("ERROR t=%0t host read was acknowledged before the competing fetch", $time);
         end
      end
   endtask

   initial begin
      void'($urandom(32'h052ccd97));
      error_count  = 0;
      reset_n      = 1'b0;
      key_mode     = 1'b1; // key idles high
      fetch_page   = '0;
      fetch_offset = '0;
      fetch_req    = 1'b0;
      wb_cyc       = 1'b0;
      wb_stb       = 1'b0;
      wb_we        = 1'b0;
      wb_adr       = '0;
      wb_dat_w     = '0;
      repeat (RESET_CYCLES) @(posedge sys_clk);
      reset_n <= 1'b1;
      mode_register_rw();
      fill_vram();
      random_host_rw();
      random_fetches();
      key_press_sequence();
      unmapped_access();
      concurrent_fetch_host();
      repeat (4) @(posedge sys_clk);
      $display("checks finished with %0d error(s)", error_count);
      if (error_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/vram_arbiter_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "compy_defines.svh"

module vram_arbiter_checker (
   input logic                   sys_clk,
   input logic                   reset_n,
   input logic                   fetch_req,
   input logic                   fetch_ack,
   input logic                   wb_cyc,
   input logic                   wb_stb,
   input logic                   wb_ack,
   input logic [`DATA_W-1:0]     wb_dat_r,
   input logic                   in_ready,
   input logic                   fetch_go,
   input compy_pkg::bus_region_t host_region
);

   import compy_pkg::*;

   logic fetch_accept;
   logic host_accept;

   assign fetch_accept = in_ready & fetch_go;                     // fetch wins in READY
   assign host_accept  = in_ready & ~fetch_go & wb_cyc & wb_stb;

   a_single_ack: assert property (@(posedge sys_clk) disable iff (!reset_n)
      !(fetch_ack && wb_ack))
      else $error("fetch ack and wb_ack are high in the same cycle");

   a_fetch_ack_req: assert property (@(posedge sys_clk) disable iff (!reset_n)
      $rose(fetch_ack) |-> fetch_req)
      else $error("fetch ack rose without a pending request");

   a_wb_ack_stb: assert property (@(posedge sys_clk) disable iff (!reset_n)
      $rose(wb_ack) |-> (wb_cyc && wb_stb))
      else $error("wb_ack rose outside a host cycle");

   a_fetch_latency: assert property (@(posedge sys_clk) disable iff (!reset_n)
      fetch_accept |-> ##3 fetch_ack)
      else $error("fetch ack did not follow acceptance by 3 cycles");

   a_host_latency: assert property (@(posedge sys_clk) disable iff (!reset_n)
      host_accept |-> ##3 wb_ack)
      else $error("wb_ack did not follow acceptance by 3 cycles");

   // unmapped host cycles answer with the fill byte
   a_unmapped_data: assert property (@(posedge sys_clk) disable iff (!reset_n)
      (wb_ack && host_region == REGION_NONE) |-> (wb_dat_r == `UNMAPPED_DATA))
      else $error("unmapped host cycle did not return the fill byte");

endmodule

`default_nettype wire
